// File: source/upct_pkg.sv
//--------------------------------------------------------------------
// shared widths and types for the upper-PC compression unit
// UPC_WIDTH is derived, so only PC_WIDTH and LPC_WIDTH are set here
// DEFAULT_UPCT_ENTRIES must be a power of two, at least 2
//--------------------------------------------------------------------

`default_nettype none

package upct_pkg;

    // full pc and its split
    localparam int PC_WIDTH  = 32;
    localparam int LPC_WIDTH = 10;
    localparam int UPC_WIDTH = PC_WIDTH - LPC_WIDTH;

    // pc types
    typedef logic [PC_WIDTH-1:0]  pc_t;
    typedef logic [UPC_WIDTH-1:0] upc_t;
    typedef logic [LPC_WIDTH-1:0] lpc_t;

    // table size used by the top level unless overridden
    localparam int DEFAULT_UPCT_ENTRIES = 8;

endpackage

`default_nettype wire

// File: source/one_hot_enc.sv
//--------------------------------------------------------------------
// one-hot to binary encoder with a valid flag
// result is only meaningful when at most one input bit is set
// WIDTH must be at least 2
//--------------------------------------------------------------------

`default_nettype none

module one_hot_enc #(
    parameter int WIDTH = 8
) (
    input  wire logic [WIDTH-1:0]         one_hot_in,
    output logic                          valid_out,
    output logic [$clog2(WIDTH)-1:0]      index_out
);

    localparam int IDX_W = $clog2(WIDTH);

    // any bit set
    assign valid_out = |one_hot_in;

    // or of the indices of all set bits
    // no priority, so two set bits give a merged index
    always_comb begin
        index_out = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (one_hot_in[i]) begin
                index_out = index_out | IDX_W'(i);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/plru_updater.sv
//--------------------------------------------------------------------
// binary-tree pseudo-LRU, next state and victim, combinational only
// node 0 is the root, children of n are 2n+1 and 2n+2
// a node bit of 0 points at the lower half
// new_valid and touch_valid must not both be high
//--------------------------------------------------------------------

`default_nettype none

module plru_updater #(
    parameter int NUM_ENTRIES = 8
) (
    // only used by the assertion
    input  wire logic                           CLK,
    input  wire logic                           nRST,

    // current tree
    input  wire logic [NUM_ENTRIES-2:0]         plru_in,

    // victim allocation
    input  wire logic                           new_valid,
    output logic [$clog2(NUM_ENTRIES)-1:0]      new_index,

    // touch of an existing entry
    input  wire logic                           touch_valid,
    input  wire logic [$clog2(NUM_ENTRIES)-1:0] touch_index,

    // next tree
    output logic [NUM_ENTRIES-2:0]              plru_out
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    // index whose path gets flipped
    logic [IDX_W-1:0] touch_sel;

    //--------------------------------------------------------------------
    // victim walk
    //--------------------------------------------------------------------

    // follow the pointers from the root, msb of the index first
    always_comb begin
        int node;
        node = 0;
        new_index = '0;
        for (int lvl = 0; lvl < IDX_W; lvl++) begin
            new_index[IDX_W-1-lvl] = plru_in[node];
            node = 2 * node + 1 + int'(plru_in[node]);
        end
    end

    //--------------------------------------------------------------------
    // touch
    //--------------------------------------------------------------------

    // allocation touches the victim it hands out
    assign touch_sel = new_valid ? new_index : touch_index;

    // point every node on the path away from the touched half
    always_comb begin
        int node;
        node = 0;
        plru_out = plru_in;
        if (new_valid || touch_valid) begin
            for (int lvl = 0; lvl < IDX_W; lvl++) begin
                plru_out[node] = ~touch_sel[IDX_W-1-lvl];
                node = 2 * node + 1 + int'(touch_sel[IDX_W-1-lvl]);
            end
        end
    end

    //--------------------------------------------------------------------
    // checks
    //--------------------------------------------------------------------

    // table control must pick one source of change per cycle
    a_single_source : assert property (
        @(posedge CLK) disable iff (!nRST)
        !(new_valid && touch_valid)
    ) else $error("plru: allocation and touch in the same cycle");

endmodule

`default_nettype wire

// File: source/upct.sv
//--------------------------------------------------------------------
// upper pc table, flip-flop array with cam lookup and plru replacement
// reads and updates see the array as it was at the start of the cycle
// an update wins the plru over a read in the same cycle
// reset fills every entry with upper pc zero
//--------------------------------------------------------------------

`default_nettype none

module upct import upct_pkg::*; #(
    parameter int UPCT_ENTRIES = DEFAULT_UPCT_ENTRIES
) (
    input  wire logic                            CLK,
    input  wire logic                            nRST,

    // read port, from the expander
    input  wire logic                            read_valid,
    input  wire logic [$clog2(UPCT_ENTRIES)-1:0] read_index,
    output upc_t                                 read_upc,

    // update port, from the packer
    input  wire logic                            update_valid,
    input  wire upc_t                            update_upc,
    output logic [$clog2(UPCT_ENTRIES)-1:0]      update_upct_index
);

    localparam int IDX_W = $clog2(UPCT_ENTRIES);

    //--------------------------------------------------------------------
    // state
    //--------------------------------------------------------------------

    // entry array and tree bits
    upc_t [UPCT_ENTRIES-1:0] upct_array;
    upc_t [UPCT_ENTRIES-1:0] next_upct_array;
    logic [UPCT_ENTRIES-2:0] plru;
    logic [UPCT_ENTRIES-2:0] next_plru;

    // entries replaced at least once since reset
    logic [UPCT_ENTRIES-1:0] entry_written;

    // cam results
    logic [UPCT_ENTRIES-1:0] match_vec;
    logic                    match_hit;
    logic [IDX_W-1:0]        match_index;

    // plru controls
    logic                    plru_new_valid;
    logic [IDX_W-1:0]        plru_new_index;
    logic                    plru_touch_valid;
    logic [IDX_W-1:0]        plru_touch_index;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            upct_array    <= '0;
            plru          <= '0;
            entry_written <= '0;
        end else begin
            upct_array <= next_upct_array;
            plru       <= next_plru;
            if (plru_new_valid) begin
                entry_written[plru_new_index] <= 1'b1;
            end
        end
    end

    //--------------------------------------------------------------------
    // lookup
    //--------------------------------------------------------------------

    // plain array read, old contents
    assign read_upc = upct_array[read_index];

    // compare against every entry
    always_comb begin
        for (int i = 0; i < UPCT_ENTRIES; i++) begin
            match_vec[i] = (upct_array[i] == update_upc);
        end
    end

    one_hot_enc #(
        .WIDTH(UPCT_ENTRIES)
    ) cam_enc (
        .one_hot_in(match_vec),
        .valid_out (match_hit),
        .index_out (match_index)
    );

    //--------------------------------------------------------------------
    // control
    //--------------------------------------------------------------------

    // hit returns the match, anything else advertises the victim
    assign update_upct_index = match_hit ? match_index : plru_new_index;

    // miss allocates, hit touches, read touches only when idle
    assign plru_new_valid   = update_valid && !match_hit;
    assign plru_touch_valid = (update_valid && match_hit) || (!update_valid && read_valid);
    assign plru_touch_index = update_valid ? match_index : read_index;

    // victim entry takes the new upper pc
    always_comb begin
        next_upct_array = upct_array;
        if (plru_new_valid) begin
            next_upct_array[plru_new_index] = update_upc;
        end
    end

    plru_updater #(
        .NUM_ENTRIES(UPCT_ENTRIES)
    ) plru_upd (
        .CLK        (CLK),
        .nRST       (nRST),
        .plru_in    (plru),
        .new_valid  (plru_new_valid),
        .new_index  (plru_new_index),
        .touch_valid(plru_touch_valid),
        .touch_index(plru_touch_index),
        .plru_out   (next_plru)
    );

    // entries stay distinct once the reset zeros are all gone
    a_cam_unique : assert property (
        @(posedge CLK) disable iff (!nRST)
        (update_valid && (&entry_written)) |-> $onehot0(match_vec)
    ) else $error("upct: more than one entry matches the update");

endmodule

`default_nettype wire

// File: source/target_packer.sv
//--------------------------------------------------------------------
// splits a target pc into a table update and the lower bits
// registered result with a one-cycle latency and one target per cycle
// no back-pressure since the table answers in the same cycle
//--------------------------------------------------------------------

`default_nettype none

module target_packer import upct_pkg::*; #(
    parameter int UPCT_ENTRIES = DEFAULT_UPCT_ENTRIES
) (
    input  wire logic                            CLK,
    input  wire logic                            nRST,

    // incoming target
    input  wire logic                            target_valid,
    input  wire pc_t                             target_pc,

    // table update
    output logic                                 update_valid,
    output upc_t                                 update_upc,
    input  wire logic [$clog2(UPCT_ENTRIES)-1:0] update_upct_index,

    // packed result
    output logic                                 packed_valid,
    output logic [$clog2(UPCT_ENTRIES)-1:0]      packed_index,
    output lpc_t                                 packed_lpc
);

    // upper part goes to the table straight away
    assign update_valid = target_valid;
    assign update_upc   = target_pc[PC_WIDTH-1:LPC_WIDTH];

    // valid strobe
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            packed_valid <= 1'b0;
        end else begin
            packed_valid <= target_valid;
        end
    end

    // payload held between targets
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            packed_index <= '0;
            packed_lpc   <= '0;
        end else if (target_valid) begin
            packed_index <= update_upct_index;
            packed_lpc   <= target_pc[LPC_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// File: source/pc_expander.sv
//--------------------------------------------------------------------
// rebuilds a full pc from a table index and the lower bits
// registered result with a one-cycle latency and one request per cycle
// sees table contents from before any same-cycle replacement
//--------------------------------------------------------------------

`default_nettype none

module pc_expander import upct_pkg::*; #(
    parameter int UPCT_ENTRIES = DEFAULT_UPCT_ENTRIES
) (
    input  wire logic                            CLK,
    input  wire logic                            nRST,

    // packed pointer in
    input  wire logic                            expand_valid,
    input  wire logic [$clog2(UPCT_ENTRIES)-1:0] expand_index,
    input  wire lpc_t                            expand_lpc,

    // table read
    output logic                                 read_valid,
    output logic [$clog2(UPCT_ENTRIES)-1:0]      read_index,
    input  wire upc_t                            read_upc,

    // rebuilt pc
    output logic                                 pc_valid,
    output pc_t                                  pc
);

    // read request passes straight through
    assign read_valid = expand_valid;
    assign read_index = expand_index;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pc_valid <= 1'b0;
        end else begin
            pc_valid <= expand_valid;
        end
    end

    // upper part from the table and lower bits from the request
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pc <= '0;
        end else if (expand_valid) begin
            pc <= {read_upc, expand_lpc};
        end
    end

    // valid must be clean once out of reset
    a_valid_known : assert property (
        @(posedge CLK) disable iff (!nRST)
        !$isunknown(pc_valid)
    ) else $error("pc_expander: pc_valid is unknown");

endmodule

`default_nettype wire

// File: source/upct_unit.sv
//--------------------------------------------------------------------
// upper-pc compression unit, packer and expander around one table
// both paths take one item per cycle with a fixed one-cycle latency
// UPCT_ENTRIES must be a power of two, at least 2
//--------------------------------------------------------------------

`default_nettype none

module upct_unit import upct_pkg::*; #(
    parameter int UPCT_ENTRIES = DEFAULT_UPCT_ENTRIES
) (
    input  wire logic                            CLK,
    input  wire logic                            nRST,

    // packing path
    input  wire logic                            target_valid,
    input  wire pc_t                             target_pc,
    output logic                                 packed_valid,
    output logic [$clog2(UPCT_ENTRIES)-1:0]      packed_index,
    output lpc_t                                 packed_lpc,

    // expanding path
    input  wire logic                            expand_valid,
    input  wire logic [$clog2(UPCT_ENTRIES)-1:0] expand_index,
    input  wire lpc_t                            expand_lpc,
    output logic                                 pc_valid,
    output pc_t                                  pc
);

    localparam int IDX_W = $clog2(UPCT_ENTRIES);

    // packer to table
    logic             update_valid;
    upc_t             update_upc;
    logic [IDX_W-1:0] update_upct_index;

    // expander to table
    logic             read_valid;
    logic [IDX_W-1:0] read_index;
    upc_t             read_upc;

    target_packer #(
        .UPCT_ENTRIES(UPCT_ENTRIES)
    ) packer (
        .CLK              (CLK),
        .nRST             (nRST),
        .target_valid     (target_valid),
        .target_pc        (target_pc),
        .update_valid     (update_valid),
        .update_upc       (update_upc),
        .update_upct_index(update_upct_index),
        .packed_valid     (packed_valid),
        .packed_index     (packed_index),
        .packed_lpc       (packed_lpc)
    );

    pc_expander #(
        .UPCT_ENTRIES(UPCT_ENTRIES)
    ) expander (
        .CLK         (CLK),
        .nRST        (nRST),
        .expand_valid(expand_valid),
        .expand_index(expand_index),
        .expand_lpc  (expand_lpc),
        .read_valid  (read_valid),
        .read_index  (read_index),
        .read_upc    (read_upc),
        .pc_valid    (pc_valid),
        .pc          (pc)
    );

    upct #(
        .UPCT_ENTRIES(UPCT_ENTRIES)
    ) table_i (
        .CLK              (CLK),
        .nRST             (nRST),
        .read_valid       (read_valid),
        .read_index       (read_index),
        .read_upc         (read_upc),
        .update_valid     (update_valid),
        .update_upc       (update_upc),
        .update_upct_index(update_upct_index)
    );

endmodule

`default_nettype wire

// File: bench/upct_unit_tb_checks.svh
//--------------------------------------------------------------------
// compare tasks and lfsr, included inside the upct_unit testbench
// needs IDX_W and the four error counters declared before the include
//--------------------------------------------------------------------

`ifndef UPCT_UNIT_TB_CHECKS_SVH
`define UPCT_UNIT_TB_CHECKS_SVH

// galois lfsr, 16 bits, taps 16 14 13 11
logic [15:0] lfsr_state = 16'd96;

task automatic check_index(input string name, input logic [IDX_W-1:0] got,
                           input logic [IDX_W-1:0] exp);
    if (got !== exp) begin
        index_errors++;
        $display("CHECK FAILED %s: expected 0x%h, got 0x%h at %0t", name, exp, got, $time);
    end
endtask

task automatic check_lpc(input string name, input lpc_t got, input lpc_t exp);
    if (got !== exp) begin
        lpc_errors++;
        $display("CHECK FAILED %s: expected 0x%h, got 0x%h at %0t", name, exp, got, $time);
    end
endtask

task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp) begin
        pc_errors++;
        $display("CHECK FAILED %s: expected 0x%h, got 0x%h at %0t", name, exp, got, $time);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        bit_errors++;
        $display("CHECK FAILED %s: expected 0x%h, got 0x%h at %0t", name, exp, got, $time);
    end
endtask

// one step, returns the bit shifted out
function automatic logic step_lfsr();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out_bit;
endfunction

// msb first, one step per bit
function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
        bits = {bits[30:0], step_lfsr()};
    end
    return bits;
endfunction

`endif

// File: bench/upct_unit_tb.sv
//--------------------------------------------------------------------
// directed and lfsr tests for upct_unit with 8 entries
// model predicts each result when its input is driven
// inputs change and outputs are checked 10 ns after the rising edge
//--------------------------------------------------------------------

`default_nettype none

module upct_unit_tb import upct_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ENTRIES       = 8;
    localparam int IDX_W         = $clog2(ENTRIES);
    localparam int RANDOM_CYCLES = 200;
    // reset 5, fill 12, hit 10, touch 8, same cycle 5, random plus drain
    localparam int TEST_CYCLES   = 5 + 12 + 10 + 8 + 5 + RANDOM_CYCLES + 1;
    localparam int CYCLE_LIMIT   = 2 * TEST_CYCLES;

    logic CLK, nRST;
    logic target_valid, packed_valid, expand_valid, pc_valid;
    pc_t  target_pc, pc;
    lpc_t packed_lpc, expand_lpc;
    logic [IDX_W-1:0] packed_index, expand_index;

    int index_errors, lpc_errors, pc_errors, bit_errors, cycle_count;

    // reference model and pending expectations
    upc_t model_upct [ENTRIES];
    logic [ENTRIES-2:0] model_plru;
    logic exp_packed_valid, exp_pc_valid;
    logic [IDX_W-1:0] exp_packed_index, last_pack_index;
    lpc_t exp_packed_lpc;
    pc_t  exp_pc;
    upc_t fill_upc [ENTRIES];

    `include "upct_unit_tb_checks.svh"

    upct_unit #(.UPCT_ENTRIES(ENTRIES)) uut (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    //--------------------------------------------------------------------
    // reference model of the table and tree
    //--------------------------------------------------------------------

    // walk from the root where bit 0 means lower half
    function automatic int find_victim(input logic [ENTRIES-2:0] tree);
        int node, lo, span;
        node = 0;
        lo   = 0;
        span = ENTRIES;
        while (span > 1) begin
            span = span / 2;
            if (tree[node[IDX_W-1:0]]) begin
                lo   = lo + span;
                node = 2 * node + 2;
            end else begin
                node = 2 * node + 1;
            end
        end
        return lo;
    endfunction

    // every node on the path points away from idx
    function automatic logic [ENTRIES-2:0] touch_path(input logic [ENTRIES-2:0] tree,
                                                      input int idx);
        logic [ENTRIES-2:0] result;
        int node, lo, span;
        result = tree;
        node   = 0;
        lo     = 0;
        span   = ENTRIES;
        while (span > 1) begin
            span = span / 2;
            result[node[IDX_W-1:0]] = (idx < lo + span);
            if (idx < lo + span) begin
                node = 2 * node + 1;
            end else begin
                lo   = lo + span;
                node = 2 * node + 2;
            end
        end
        return result;
    endfunction

    function automatic int lookup_upc(input upc_t upc);
        int found;
        found = -1;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (model_upct[i] == upc) begin
                found = i;
            end
        end
        return found;
    endfunction

    //--------------------------------------------------------------------
    // cycle driver
    //--------------------------------------------------------------------

    // check last cycle's results before predicting and driving this one
    task automatic run_cycle(input logic tv, input pc_t tpc, input logic ev,
                             input logic [IDX_W-1:0] eidx, input lpc_t elpc);
        int slot;
        @(posedge CLK);
        #10;
        check_bit("packed_valid", packed_valid, exp_packed_valid);
        if (exp_packed_valid) begin
            check_index("packed_index", packed_index, exp_packed_index);
            check_lpc("packed_lpc", packed_lpc, exp_packed_lpc);
        end
        check_bit("pc_valid", pc_valid, exp_pc_valid);
        if (exp_pc_valid) begin
            check_pc("pc", pc, exp_pc);
        end
        // read sees the table before this cycle's write
        exp_pc_valid     = ev;
        exp_pc           = {model_upct[eidx], elpc};
        exp_packed_valid = tv;
        exp_packed_lpc   = tpc[LPC_WIDTH-1:0];
        if (tv) begin
            slot = lookup_upc(tpc[PC_WIDTH-1:LPC_WIDTH]);
            if (slot < 0) begin
                slot = find_victim(model_plru);
                model_upct[slot] = tpc[PC_WIDTH-1:LPC_WIDTH];
            end
            exp_packed_index = slot[IDX_W-1:0];
            last_pack_index  = slot[IDX_W-1:0];
            model_plru = touch_path(model_plru, slot);
        end else if (ev) begin
            model_plru = touch_path(model_plru, int'(eidx));
        end
        target_valid = tv;
        target_pc    = tpc;
        expand_valid = ev;
        expand_index = eidx;
        expand_lpc   = elpc;
    endtask

    task automatic pack_target(input pc_t tpc);
        run_cycle(1'b1, tpc, 1'b0, '0, '0);
    endtask

    task automatic expand_pointer(input logic [IDX_W-1:0] idx, input lpc_t lpc);
        run_cycle(1'b0, '0, 1'b1, idx, lpc);
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic apply_reset();
        nRST         = 1'b0;
        // strobes held high through reset must not reach the outputs
        target_valid = 1'b1;
        target_pc    = '0;
        expand_valid = 1'b1;
        expand_index = '0;
        expand_lpc   = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            model_upct[i] = '0;
        end
        model_plru       = '0;
        exp_packed_valid = 1'b0;
        exp_pc_valid     = 1'b0;
        repeat (3) @(posedge CLK);
        #10;
        check_bit("packed_valid", packed_valid, 1'b0);
        check_bit("pc_valid", pc_valid, 1'b0);
        target_valid = 1'b0;
        expand_valid = 1'b0;
        nRST         = 1'b1;
    endtask

    //--------------------------------------------------------------------
    // tests
    //--------------------------------------------------------------------

    task automatic reset_contents();
        apply_reset();
        // all entries zero so only the lower bits come back
        expand_pointer(IDX_W'(3), 10'h155);
        idle_cycle();
    endtask

    task automatic fill_table();
        apply_reset();
        for (int i = 0; i < ENTRIES; i++) begin
            fill_upc[i] = upc_t'(22'h0A5000 + i * 22'h01357);
            pack_target({fill_upc[i], lpc_t'(10'h0A0 + i * 3)});
        end
        idle_cycle();
    endtask

    task automatic hit_stored();
        pack_target({fill_upc[3], 10'h3C3});
        // contents must be untouched
        for (int i = 0; i < ENTRIES; i++) begin
            expand_pointer(IDX_W'(i), lpc_t'(i));
        end
        idle_cycle();
    endtask

    task automatic replace_after_touch();
        // read the two current victims and entry 5 before two hits
        expand_pointer(IDX_W'(find_victim(model_plru)), 10'h011);
        expand_pointer(IDX_W'(find_victim(model_plru)), 10'h022);
        expand_pointer(IDX_W'(5), 10'h033);
        pack_target({model_upct[find_victim(model_plru)], 10'h044});
        pack_target({fill_upc[0], 10'h055});
        pack_target({22'h2F0F0F, 10'h066});
        expand_pointer(last_pack_index, 10'h077);
        idle_cycle();
    endtask

    task automatic read_during_miss();
        int victim;
        victim = find_victim(model_plru);
        // read of the victim while it is replaced
        run_cycle(1'b1, {22'h31C001, 10'h101}, 1'b1, IDX_W'(victim), 10'h202);
        // read elsewhere leaves the tree to the miss
        run_cycle(1'b1, {22'h31C002, 10'h103}, 1'b1,
                  IDX_W'((find_victim(model_plru) + ENTRIES / 2) % ENTRIES), 10'h204);
        pack_target({22'h31C003, 10'h105});
        expand_pointer(IDX_W'(victim), 10'h206);
        idle_cycle();
    endtask

    task automatic random_traffic();
        logic tv, reuse, ev;
        logic [IDX_W-1:0] pick, idx;
        upc_t upc;
        lpc_t lpc, elpc;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            tv    = step_lfsr();
            reuse = step_lfsr();
            pick  = IDX_W'(take_bits(IDX_W));
            upc   = upc_t'(take_bits(UPC_WIDTH));
            lpc   = lpc_t'(take_bits(LPC_WIDTH));
            ev    = step_lfsr();
            idx   = IDX_W'(take_bits(IDX_W));
            elpc  = lpc_t'(take_bits(LPC_WIDTH));
            // half the packs reuse a stored upper pc
            if (reuse) begin
                upc = model_upct[pick];
            end
            run_cycle(tv, {upc, lpc}, ev, idx, elpc);
        end
        idle_cycle();
    endtask

    initial begin
        index_errors = 0;
        lpc_errors   = 0;
        pc_errors    = 0;
        bit_errors   = 0;
        nRST         = 1'b0;
        target_valid = 1'b0;
        target_pc    = '0;
        expand_valid = 1'b0;
        expand_index = '0;
        expand_lpc   = '0;
        reset_contents();
        fill_table();
        hit_stored();
        replace_after_touch();
        read_during_miss();
        random_traffic();
        $display("errors: index %0d, lpc %0d, pc %0d, valid %0d",
                 index_errors, lpc_errors, pc_errors, bit_errors);
        if (index_errors + lpc_errors + pc_errors + bit_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: upct_unit.f
+incdir+bench
source/upct_pkg.sv
source/one_hot_enc.sv
source/plru_updater.sv
source/upct.sv
source/target_packer.sv
source/pc_expander.sv
source/upct_unit.sv
bench/upct_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the upct_unit testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module upct_unit_tb \
    -f upct_unit.f -o upct_unit_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/upct_unit_sim > sim.log 2>&1
grep -qF "*** TEST PASSED ***" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
